//--- source/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
// 128 lines of 8 words, 16-bit words
`define CACHE_LINES 128
`define CACHE_WORDS 8

// backing memory read latency in cycles
// up to this many reads may be in flight
`define MEM_LATENCY 4

// word count of backing memory, one per address bits 15..1
`define MEM_WORDS 32768

// initial content: word index xor seed
`define MEM_SEED 16'h5a3c

`endif

//--- source/cache_pkg.sv
package cache_pkg;

	// one data word
	typedef logic [15:0] word_t;

	// byte address split into cache fields
	// lsb selects a byte, unused here
	typedef struct packed {
		logic [4:0] tag;
		logic [6:0] index;
		logic [2:0] offset;
		logic       byte_sel;
	} cache_addr_t;

	// one entry of the tag array
	typedef struct packed {
		logic       valid;
		logic [4:0] tag;
	} tag_entry_t;

	// requester side, held while stall is high
	typedef struct packed {
		logic        op;
		logic        write;
		cache_addr_t addr;
		word_t       data;
	} cpu_req_t;

	// memory side request
	typedef struct packed {
		logic        enable;
		logic        write;
		logic [15:0] addr;
		word_t       data;
	} mem_req_t;

	// fill engine states
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_STREAM,
		FILL_TAG
	} fill_state_e;

endpackage

//--- source/cache_data_array.sv
`include "cache_config.svh"

module cache_data_array (
	input  logic               clk,
	input  logic               write,
	input  logic [6:0]         index,
	input  logic [2:0]         offset,
	input  cache_pkg::word_t   data_in,
	output cache_pkg::word_t   data_out
);

	// line by word storage
	cache_pkg::word_t mem [`CACHE_LINES][`CACHE_WORDS];

	// one-hot enables
	logic [`CACHE_LINES-1:0] line_en;
	logic [`CACHE_WORDS-1:0] word_en;

	// index decoder, one line active
	always_comb begin
		line_en = '0;
		line_en[index] = 1'b1;
	end

	// offset decoder, one word active
	always_comb begin
		word_en = '0;
		word_en[offset] = 1'b1;
	end

	// single word written where line and word enables cross
	always_ff @(posedge clk) begin
		for (int l = 0; l < `CACHE_LINES; l++) begin
			for (int w = 0; w < `CACHE_WORDS; w++) begin
				if (write && line_en[l] && word_en[w]) begin
					mem[l][w] <= data_in;
				end
			end
		end
	end

	// async read, same index and offset as write
	assign data_out = mem[index][offset];

endmodule

//--- source/cache_tag_array.sv
`include "cache_config.svh"

module cache_tag_array (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   write,
	input  logic [6:0]             index,
	input  cache_pkg::tag_entry_t  entry_in,
	output cache_pkg::tag_entry_t  entry_out
);

	// valid plus tag, one per line
	cache_pkg::tag_entry_t entries [`CACHE_LINES];

	// reset invalidates every line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				entries[i] <= '0;
			end
		end else if (write) begin
			// fill engine replaces whole entry
			entries[index] <= entry_in;
		end
	end

	// async lookup for same-cycle hit check
	assign entry_out = entries[index];

endmodule

//--- source/cache_fill_fsm.sv
`include "cache_config.svh"

module cache_fill_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  cache_pkg::cache_addr_t line_addr,
	input  logic                   mem_valid,
	output logic                   busy,
	output cache_pkg::mem_req_t    fill_req,
	output logic                   fill_write,
	output logic [2:0]             fill_offset,
	output logic                   tag_write
);

	localparam int unsigned WORDS = `CACHE_WORDS;

	cache_pkg::fill_state_e state;

	// issue side counts 0..8, extra bit marks done
	logic [3:0] issue_cnt;
	// return side, offset of next returning word
	logic [2:0] ret_cnt;
	logic       issuing;

	// reads go out back to back while issue count below line size
	assign issuing = (state == cache_pkg::FILL_STREAM) && (issue_cnt < 4'(WORDS));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= cache_pkg::FILL_IDLE;
			issue_cnt <= '0;
			ret_cnt   <= '0;
		end else begin
			case (state)
				cache_pkg::FILL_IDLE: begin
					// start only looked at here
					if (start) begin
						state     <= cache_pkg::FILL_STREAM;
						issue_cnt <= '0;
						ret_cnt   <= '0;
					end
				end
				cache_pkg::FILL_STREAM: begin
					// issue and return overlap once latency passed
					if (issuing) begin
						issue_cnt <= issue_cnt + 4'd1;
					end
					if (mem_valid) begin
						ret_cnt <= ret_cnt + 3'd1;
						// eighth word back, tag next
						if (ret_cnt == 3'(WORDS - 1)) begin
							state <= cache_pkg::FILL_TAG;
						end
					end
				end
				cache_pkg::FILL_TAG: begin
					// one cycle for the tag write
					state <= cache_pkg::FILL_IDLE;
				end
				default: begin
					state <= cache_pkg::FILL_IDLE;
				end
			endcase
		end
	end

	assign busy = (state != cache_pkg::FILL_IDLE);

	// line address with issue count as word offset, reads only
	always_comb begin
		fill_req.enable = issuing;
		fill_req.write  = 1'b0;
		fill_req.addr   = {line_addr.tag, line_addr.index, issue_cnt[2:0], 1'b0};
		fill_req.data   = '0;
	end

	// returns arrive in order, so return count is the offset
	assign fill_write  = (state == cache_pkg::FILL_STREAM) && mem_valid;
	assign fill_offset = ret_cnt;
	assign tag_write   = (state == cache_pkg::FILL_TAG);

endmodule

//--- source/backing_memory.sv
`include "cache_config.svh"

module backing_memory (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cache_pkg::mem_req_t  req,
	output cache_pkg::word_t     rdata,
	output logic                 data_valid
);

	localparam int unsigned LAT = `MEM_LATENCY;

	cache_pkg::word_t mem [`MEM_WORDS];

	// delay line, valid and word address per stage
	logic        valid_pipe [LAT];
	logic [14:0] addr_pipe  [LAT];

	// seed pattern, word index xor seed
	initial begin
		for (int i = 0; i < `MEM_WORDS; i++) begin
			mem[i] = 16'(i) ^ `MEM_SEED;
		end
	end

	// writes land at the request edge
	always_ff @(posedge clk) begin
		if (req.enable && req.write) begin
			mem[req.addr[15:1]] <= req.data;
		end
	end

	// read valid bits shift through, cleared at reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < LAT; i++) begin
				valid_pipe[i] <= 1'b0;
			end
		end else begin
			valid_pipe[0] <= req.enable && !req.write;
			for (int i = 1; i < LAT; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	// addresses follow alongside
	always_ff @(posedge clk) begin
		addr_pipe[0] <= req.addr[15:1];
		for (int i = 1; i < LAT; i++) begin
			addr_pipe[i] <= addr_pipe[i-1];
		end
	end

	// word fetched at the last stage
	assign rdata      = mem[addr_pipe[LAT-1]];
	assign data_valid = valid_pipe[LAT-1];

endmodule

//--- source/cache_controller.sv
module cache_controller (
	input  logic                clk,
	input  logic                rst_n,
	input  cache_pkg::cpu_req_t req,
	output cache_pkg::word_t    data_out,
	output logic                stall
);

	// address fields
	cache_pkg::cache_addr_t addr;
	assign addr = req.addr;

	// tag lookup
	cache_pkg::tag_entry_t tag_entry;
	cache_pkg::tag_entry_t new_entry;

	// fill engine side
	logic                busy;
	logic                fill_write;
	logic [2:0]          fill_offset;
	logic                tag_write;
	cache_pkg::mem_req_t fill_req;

	// memory side
	cache_pkg::mem_req_t cpu_mem_req;
	cache_pkg::mem_req_t mem_req;
	cache_pkg::word_t    mem_rdata;
	logic                mem_valid;

	// data array side
	logic                miss_detected;
	logic                read_miss;
	logic                cpu_write_hit;
	logic                array_write;
	logic [2:0]          array_offset;
	cache_pkg::word_t    array_data_in;

	// miss if line invalid or tags differ
	assign miss_detected = req.op && (!tag_entry.valid || (tag_entry.tag != addr.tag));
	assign read_miss     = miss_detected && !req.write;
	// write hit updates cached copy too
	assign cpu_write_hit = req.op && req.write && !miss_detected;

	// write misses do not stall, no allocate
	assign stall = read_miss || busy;

	// fill engine owns the word select and write port while busy
	assign array_offset  = busy ? fill_offset : addr.offset;
	assign array_write   = busy ? fill_write : cpu_write_hit;
	assign array_data_in = busy ? mem_rdata : req.data;

	// new tag entry, always valid
	assign new_entry.valid = 1'b1;
	assign new_entry.tag   = addr.tag;

	// cpu only reaches memory for write-through
	always_comb begin
		cpu_mem_req.enable = req.op && req.write;
		cpu_mem_req.write  = req.write;
		cpu_mem_req.addr   = addr;
		cpu_mem_req.data   = req.data;
	end

	assign mem_req = busy ? fill_req : cpu_mem_req;

	cache_data_array data_array0 (
		.clk      (clk),
		.write    (array_write),
		.index    (addr.index),
		.offset   (array_offset),
		.data_in  (array_data_in),
		.data_out (data_out)
	);

	cache_tag_array tag_array0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.write     (tag_write),
		.index     (addr.index),
		.entry_in  (new_entry),
		.entry_out (tag_entry)
	);

	// start held during the miss, engine only sees it when idle
	cache_fill_fsm fill_fsm0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (read_miss),
		.line_addr   (addr),
		.mem_valid   (mem_valid),
		.busy        (busy),
		.fill_req    (fill_req),
		.fill_write  (fill_write),
		.fill_offset (fill_offset),
		.tag_write   (tag_write)
	);

	backing_memory memory0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (mem_req),
		.rdata      (mem_rdata),
		.data_valid (mem_valid)
	);

endmodule

//--- verif/cache_checker.sv
`include "cache_config.svh"

module cache_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                stall,
	input logic                busy,
	input logic                tag_write,
	input logic                mem_valid,
	input cache_pkg::mem_req_t cpu_mem_req
);

	timeunit 1ns;
	timeprecision 100ps;

	// longest fill, start edge plus tag cycle plus stream
	localparam int MAX_BUSY = 2 + 8 + `MEM_LATENCY;

	// busy cycles seen so far in this fill
	int busy_len;
	// memory returns seen so far in this fill
	int ret_len;

	// one flag per assertion
	logic stall_bad = 1'b0;
	logic mem_bad = 1'b0;
	logic busy_bad = 1'b0;
	logic tag_bad = 1'b0;
	logic any_failed;

	assign any_failed = stall_bad | mem_bad | busy_bad | tag_bad;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_len <= 0;
			ret_len  <= 0;
		end else if (busy) begin
			busy_len <= busy_len + 1;
			if (mem_valid) begin
				ret_len <= ret_len + 1;
			end
		end else begin
			busy_len <= 0;
			ret_len  <= 0;
		end
	end

	stall_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(stall))
		else begin
			stall_bad = 1'b1;
			$error("stall is unknown after reset");
		end

	// a cpu write during a fill would be lost at the memory mux
	no_cpu_write_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> !(cpu_mem_req.enable && cpu_mem_req.write))
		else begin
			mem_bad = 1'b1;
			$error("cpu memory write requested during a fill");
		end

	fill_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		busy |-> (busy_len < MAX_BUSY))
		else begin
			busy_bad = 1'b1;
			$error("fill engine busy too long");
		end

	// tag only after the whole line came back
	tag_write_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
		tag_write |-> (busy && (ret_len == `CACHE_WORDS)))
		else begin
			tag_bad = 1'b1;
			$error("tag written outside a fill or before the line returned");
		end

endmodule

bind cache_controller cache_checker checker0 (
	.clk         (clk),
	.rst_n       (rst_n),
	.stall       (stall),
	.busy        (busy),
	.tag_write   (tag_write),
	.mem_valid   (mem_valid),
	.cpu_mem_req (cpu_mem_req)
);

//--- verif/cache_tb.sv
module cache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                clk;
	logic                rst_n;
	cache_pkg::cpu_req_t req;
	cache_pkg::word_t    data_out;
	logic                stall;

	// vectors as read from the file
	cache_pkg::cpu_req_t req_q[$];
	logic                miss_q[$];
	cache_pkg::word_t    rdata_q[$];

	int vec_num = 0;
	int cycle_count = 0;
	// 0 until the vectors are loaded
	int cycle_limit = 0;

	cache_controller dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.data_out (data_out),
		.stall    (stall)
	);

	// 8 ns clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one entry per vector line, comment lines start with #
	task automatic load_vectors();
		int                  fd;
		int                  status;
		string               line;
		logic                op_v;
		logic                wr_v;
		logic [15:0]         addr_v;
		logic [15:0]         data_v;
		logic                miss_v;
		logic [15:0]         rdata_v;
		cache_pkg::cpu_req_t v;
		fd = $fopen("verif/cache_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vectors file verif/cache_vectors.txt");
			$display("Test FAILED");
			$fatal(1, "no vectors file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				status = $fgets(line, fd);
				if (status == 0 || line.len() < 2 || line.getc(0) == "#") begin
					continue;
				end
				status = $sscanf(line, "%h %h %h %h %h %h",
					op_v, wr_v, addr_v, data_v, miss_v, rdata_v);
				if (status == 6) begin
					v.op    = op_v;
					v.write = wr_v;
					v.addr  = addr_v;
					v.data  = data_v;
					req_q.push_back(v);
					miss_q.push_back(miss_v);
					rdata_q.push_back(rdata_v);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_word(input string name, input cache_pkg::word_t expected,
		input cache_pkg::word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h at vector %0d",
				name, expected, actual, vec_num);
			$display("Test FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h at vector %0d",
				name, expected, actual, vec_num);
			$display("Test FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// request held until stall drops, stall in first cycle is the miss flag
	task automatic run_vector(input int n);
		logic observed_miss;
		@(posedge clk);
		#1;
		req = req_q[n];
		vec_num = n;
		@(negedge clk);
		observed_miss = stall;
		while (stall) begin
			@(negedge clk);
		end
		check_flag("stall", miss_q[n], observed_miss);
		// write vectors carry no read data
		if (!req_q[n].write) begin
			check_word("data_out", rdata_q[n], data_out);
		end
	endtask

	// bounded by the vector count, also watches the bound checker
	initial begin : watchdog
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
			if (dut0.checker0.any_failed) begin
				$display("an assertion in the bound checker failed");
				$display("Test FAILED");
				$fatal(1, "assertion failure");
			end
		end
		$display("timeout after %0d cycles, the cache never released stall", cycle_count);
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

	initial begin : stimulus
		req = '0;
		rst_n = 1'b0;
		load_vectors();
		if (req_q.size() == 0) begin
			$display("the vectors file holds no vectors");
			$display("Test FAILED");
			$fatal(1, "empty vectors file");
		end
		cycle_limit = 20 * req_q.size() + 100;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int n = 0; n < req_q.size(); n++) begin
			run_vector(n);
		end
		@(posedge clk);
		#1;
		req = '0;
		@(posedge clk);
		if (dut0.checker0.any_failed) begin
			$display("an assertion in the bound checker failed");
			$display("Test FAILED");
			$fatal(1, "assertion failure");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- verif/cache_vectors.txt
# op write addr data miss rdata, all hex
# miss is stall in the first cycle of the request, rdata is checked on reads only
1 0 1230 0000 1 5324
1 0 1232 0000 0 5325
1 0 1234 0000 0 5326
1 0 1236 0000 0 5327
1 0 1238 0000 0 5320
1 0 123a 0000 0 5321
1 0 123c 0000 0 5322
1 0 123e 0000 0 5323
1 0 1230 0000 0 5324
1 0 1231 0000 0 5324
1 1 1236 beef 0 0000
1 0 1236 0000 0 beef
1 0 1234 0000 0 5326
1 1 4a50 c0de 0 0000
1 0 4a50 0000 1 c0de
1 0 4a52 0000 0 7f15
1 0 5a30 0000 1 7724
1 0 5a3e 0000 0 7723
1 0 1236 0000 1 beef
1 0 1230 0000 0 5324
1 0 5a38 0000 1 7720
1 0 0000 0000 1 5a3c
1 0 0002 0000 0 5a3d
1 0 fffe 0000 1 25c3
1 0 fff0 0000 0 25c4

//--- list.f
+incdir+source
source/cache_pkg.sv
source/cache_data_array.sv
source/cache_tag_array.sv
source/cache_fill_fsm.sv
source/backing_memory.sv
source/cache_controller.sv
verif/cache_checker.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module cache_tb -o cache_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1
cat sim.log
grep -q "^Test OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
